// ==== flist.f ====
+incdir+test
design/fetchPkg.sv
design/preDecode.sv
design/returnStack.sv
design/ctrlQueue.sv
design/fetchStage2.sv
design/fetchSubsystem.sv
test/tbFetchSubsystem.sv

// ==== test/tbFetchModel.svh ====
/*
 * Fetch slice reference model: control queue and return stack
 * mirror, Galois LFSR source, instruction generator, slot decode
 */
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

  logic [31:0] lfsrState = 32'd89445;

  pcT       modelPc    [QDEPTH];
  ctrlTypeE modelType  [QDEPTH];
  pcT       modelTarget[QDEPTH];
  logic     modelTaken [QDEPTH];
  pcT       modelStack [SDEPTH] = '{default: '0};
  int       modelHead  = 0;
  int       modelTail  = 0;
  int       modelCount = 0;
  int       modelSp    = 0;

  logic     updPending = 1'b0;  // commit retired last cycle
  pcT       updPcExp;
  pcT       updTargetExp;
  ctrlTypeE updTypeExp;
  logic     updTakenExp;

  // one Galois step per bit taken
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits      = {bits[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hA300_0000) : (lfsrState >> 1);
    end
    return bits;
  endfunction

  function automatic instT makeInst();
    logic isCti;
    isCti = (takeBits(5) < 13);  // 13 of 32
    return {isCti, 2'(takeBits(2)), 29'(takeBits(29))};
  endfunction

  function automatic instT slotInstOf(input int k);
    return instBundle_i[k*INST_WIDTH +: INST_WIDTH];
  endfunction

  function automatic logic slotIsCtrl(input int k);
    instT inst;
    inst = slotInstOf(k);
    return inst[31];
  endfunction

  function automatic ctrlTypeE slotTypeOf(input int k);
    instT inst;
    inst = slotInstOf(k);
    case (inst[30:29])
      2'b00:   return CTRL_COND;
      2'b01:   return CTRL_JUMP;
      2'b10:   return CTRL_CALL;
      default: return CTRL_RETURN;
    endcase
  endfunction

  function automatic logic slotTakenCtrl(input int k);
    return slotIsCtrl(k) && (prediction_i[k] || slotTypeOf(k) != CTRL_COND);
  endfunction

  function automatic pcT slotTargetOf(input int k);
    instT inst;
    inst = slotInstOf(k);
    if (slotIsCtrl(k) && slotTypeOf(k) == CTRL_RETURN) begin
      return modelStack[modelSp];
    end
    return pc_i + pcT'(4 * k) + {{14{inst[15]}}, inst[15:0], 2'b00};
  endfunction

  // one rising edge of the queue and the return stack
  task automatic stepModel(input logic fire, input int first, input logic hasTaken);
    int   idx;
    logic squash;
    squash     = resolveValid_i && resolveMispredict_i;
    idx        = int'(resolveIndex_i);
    updPending = commit_i && (modelCount != 0);
    if (updPending) begin
      updPcExp     = modelPc[modelHead];
      updTargetExp = modelTarget[modelHead];
      updTypeExp   = modelType[modelHead];
      updTakenExp  = modelTaken[modelHead];
    end
    if (fire && !squash) begin
      for (int k = 0; k <= first; k++) begin
        if (slotIsCtrl(k)) begin
          modelPc[modelTail]     = pc_i + pcT'(4 * k);
          modelType[modelTail]   = slotTypeOf(k);
          modelTarget[modelTail] = slotTargetOf(k);
          modelTaken[modelTail]  = prediction_i[k] || (slotTypeOf(k) != CTRL_COND);
          modelTail              = (modelTail + 1) % QDEPTH;
          modelCount++;
        end
      end
    end
    if (resolveValid_i) begin
      modelTarget[idx] = resolveTarget_i;
      modelTaken[idx]  = resolveTaken_i;
    end
    if (squash) begin
      modelCount = (idx - modelHead + QDEPTH) % QDEPTH + 1;  // head up to idx survive
      modelTail  = (idx + 1) % QDEPTH;
    end
    if (updPending) begin
      modelHead = (modelHead + 1) % QDEPTH;
      modelCount--;
    end
    if (fire && hasTaken && slotTypeOf(first) == CTRL_CALL) begin
      modelSp             = (modelSp + 1) % SDEPTH;
      modelStack[modelSp] = pc_i + pcT'(4 * first + 4);
    end else if (fire && hasTaken && slotTypeOf(first) == CTRL_RETURN) begin
      modelSp = (modelSp + SDEPTH - 1) % SDEPTH;
    end
  endtask

`endif

// ==== test/tbFetchSubsystem.sv ====
/*
 * Fetch slice testbench: random bundles, resolves and commits,
 * each cycle compared with the reference model
 */
`timescale 1ns/1ns
`default_nettype none

module tbFetchSubsystem;
  import fetchPkg::*;

  localparam int QDEPTH         = 16;
  localparam int SDEPTH         = 8;
  localparam int NUM_CYCLES     = 3000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 3;

  logic     clk = 1'b0;
  logic     reset_i;
  logic     fs1Ready_i;
  logic     stall_i;
  pcT       pc_i;
  logic [FETCH_WIDTH*INST_WIDTH-1:0]   instBundle_i;
  logic [FETCH_WIDTH-1:0]              btbHit_i;
  logic [FETCH_WIDTH-1:0]              prediction_i;
  logic     resolveValid_i;
  ctiTagT   resolveIndex_i;
  pcT       resolveTarget_i;
  logic     resolveTaken_i;
  logic     resolveMispredict_i;
  logic     commit_i;
  logic [FETCH_WIDTH-1:0]              instValid_o;
  logic [FETCH_WIDTH*PACKET_WIDTH-1:0] instPacket_o;
  logic     flagRecover_o;
  logic     flagRtr_o;
  logic     flagCall_o;
  pcT       targetAddr_o;
  pcT       callPc_o;
  logic     fs2Ready_o;
  logic     ctiQueueFull_o;
  pcT       updatePc_o;
  pcT       updateTarget_o;
  ctrlTypeE updateCtrlType_o;
  logic     updateTaken_o;
  logic     updateEn_o;
  int       cycleCount = 0;
  logic     lastFire   = 1'b1;

  `include "tbFetchModel.svh"

  fetchSubsystem #(
    .CTIQ_DEPTH(QDEPTH),
    .RAS_DEPTH (SDEPTH)
  ) u_fetchSubsystem (.*);

  always #10 clk = ~clk;

  always @(posedge clk) cycleCount <= cycleCount + 1;

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic checkValue(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    assert (got === exp)
      else stopWithFailure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus, driven after the falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic driveInputs(input logic holdBundle);
    int idx;
    if (!holdBundle) begin
      pc_i = takeBits(30) << 2;
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        instBundle_i[k*INST_WIDTH +: INST_WIDTH] = makeInst();
      end
      btbHit_i     = 4'(takeBits(4));
      prediction_i = 4'(takeBits(4));
    end
    fs1Ready_i          = (takeBits(3) != 0);
    stall_i             = (takeBits(3) == 0);
    commit_i            = (takeBits(1) != 0);
    resolveValid_i      = 1'b0;
    resolveIndex_i      = '0;
    resolveTarget_i     = '0;
    resolveTaken_i      = 1'b0;
    resolveMispredict_i = 1'b0;
    if (modelCount > 0 && takeBits(2) == 0) begin
      idx                 = (modelHead + int'(takeBits(4)) % modelCount) % QDEPTH;
      resolveValid_i      = 1'b1;
      resolveIndex_i      = ctiTagT'(idx);
      resolveTarget_i     = takeBits(30) << 2;
      resolveTaken_i      = (takeBits(1) != 0);
      resolveMispredict_i = (takeBits(3) == 0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output checks against the model, then one model step
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic checkCycle();
    logic [PACKET_WIDTH-1:0] pkt;
    logic [FETCH_WIDTH-1:0]  expValid;
    logic hasTaken;
    logic full;
    logic fire;
    logic miss;
    int   first;
    int   ctrlSeen;
    hasTaken = 1'b0;
    first    = FETCH_WIDTH - 1;  // no taken slot keeps all four
    for (int k = FETCH_WIDTH - 1; k >= 0; k--) begin
      if (slotTakenCtrl(k)) begin
        hasTaken = 1'b1;
        first    = k;
      end
    end
    full     = (modelCount > QDEPTH - FETCH_WIDTH);
    fire     = fs1Ready_i && !stall_i && !full;
    miss     = hasTaken && !btbHit_i[first];
    ctrlSeen = 0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      expValid[k] = (k <= first);
    end
    checkValue("instValid_o", instValid_o, expValid);
    checkValue("targetAddr_o", targetAddr_o, slotTargetOf(first));
    checkValue("callPc_o", callPc_o, pc_i + pcT'(4 * first));
    checkValue("flagRtr_o", flagRtr_o, miss && slotTypeOf(first) == CTRL_RETURN);
    checkValue("flagCall_o", flagCall_o, miss && slotTypeOf(first) == CTRL_CALL);
    checkValue("flagRecover_o", flagRecover_o, miss && !stall_i && !full);
    checkValue("fs2Ready_o", fs2Ready_o, fs1Ready_i && !full);
    checkValue("ctiQueueFull_o", ctiQueueFull_o, full);
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      pkt = instPacket_o[k*PACKET_WIDTH +: PACKET_WIDTH];
      checkValue($sformatf("instPacket_o[%0d].inst", k), pkt[PACKET_WIDTH-1 -: INST_WIDTH],
                 slotInstOf(k));
      checkValue($sformatf("instPacket_o[%0d].pc", k), pkt[TAG_WIDTH+2*PC_WIDTH -: PC_WIDTH],
                 pc_i + pcT'(4 * k));
      checkValue($sformatf("instPacket_o[%0d].target", k), pkt[TAG_WIDTH+PC_WIDTH -: PC_WIDTH],
                 slotTargetOf(k));
      checkValue($sformatf("instPacket_o[%0d].pred", k), pkt[0], prediction_i[k]);
      if (expValid[k] && slotIsCtrl(k)) begin
        checkValue($sformatf("instPacket_o[%0d].tag", k), pkt[TAG_WIDTH:1],
                   (modelTail + ctrlSeen) % QDEPTH);
        ctrlSeen++;
      end
    end
    checkValue("updateEn_o", updateEn_o, updPending);
    if (updPending) begin
      checkValue("updatePc_o", updatePc_o, updPcExp);
      checkValue("updateTarget_o", updateTarget_o, updTargetExp);
      checkValue("updateCtrlType_o", updateCtrlType_o, updTypeExp);
      checkValue("updateTaken_o", updateTaken_o, updTakenExp);
    end
    lastFire = fire;
    stepModel(fire, first, hasTaken);
  endtask

  initial begin
    reset_i             = 1'b1;
    fs1Ready_i          = 1'b0;
    stall_i             = 1'b0;
    pc_i                = '0;
    instBundle_i        = '0;
    btbHit_i            = '0;
    prediction_i        = '0;
    resolveValid_i      = 1'b0;
    resolveIndex_i      = '0;
    resolveTarget_i     = '0;
    resolveTaken_i      = 1'b0;
    resolveMispredict_i = 1'b0;
    commit_i            = 1'b0;
    repeat (2) @(posedge clk);
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(negedge clk);
      reset_i = 1'b0;
      driveInputs(!lastFire && takeBits(1) != 0);  // producer may hold a refused bundle
      #9;
      checkCycle();
    end
    $display("Testbench passed");
    $finish;
  end

  initial begin : watchdog
    wait (cycleCount >= TIMEOUT_CYCLES);
    stopWithFailure("run did not finish within the cycle limit");
  end

endmodule

`default_nettype wire

// ==== design/fetchSubsystem.sv ====
/*
 * Fetch slice top: stage 2 with its control queue and
 * the return address stack
 */
`timescale 1ns/1ns
`default_nettype none

module fetchSubsystem #(
  parameter int CTIQ_DEPTH = 16,
  parameter int RAS_DEPTH  = 8
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               fs1Ready_i,
  input  logic               stall_i,
  input  fetchPkg::pcT       pc_i,
  input  logic [fetchPkg::FETCH_WIDTH*fetchPkg::INST_WIDTH-1:0] instBundle_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0] btbHit_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0] prediction_i,
  input  logic               resolveValid_i,
  input  fetchPkg::ctiTagT   resolveIndex_i,
  input  fetchPkg::pcT       resolveTarget_i,
  input  logic               resolveTaken_i,
  input  logic               resolveMispredict_i,
  input  logic               commit_i,
  output logic [fetchPkg::FETCH_WIDTH-1:0] instValid_o,
  output logic [fetchPkg::FETCH_WIDTH*fetchPkg::PACKET_WIDTH-1:0] instPacket_o,
  output logic               flagRecover_o,
  output logic               flagRtr_o,
  output logic               flagCall_o,
  output fetchPkg::pcT       targetAddr_o,
  output fetchPkg::pcT       callPc_o,
  output logic               fs2Ready_o,
  output logic               ctiQueueFull_o,
  output fetchPkg::pcT       updatePc_o,
  output fetchPkg::pcT       updateTarget_o,
  output fetchPkg::ctrlTypeE updateCtrlType_o,
  output logic               updateTaken_o,
  output logic               updateEn_o
);
  import fetchPkg::*;

  pcT   rasTop;
  pcT   callPc;
  pcT   returnAddr;
  logic rasPush;
  logic rasPop;

  assign callPc_o   = callPc;
  assign returnAddr = callPc + pcT'(4);  // instruction after the call

  fetchStage2 #(
    .CTIQ_DEPTH(CTIQ_DEPTH)
  ) u_fetchStage2 (
    .clk                (clk),
    .reset_i            (reset_i),
    .fs1Ready_i         (fs1Ready_i),
    .stall_i            (stall_i),
    .pc_i               (pc_i),
    .instBundle_i       (instBundle_i),
    .btbHit_i           (btbHit_i),
    .prediction_i       (prediction_i),
    .rasTop_i           (rasTop),
    .resolveValid_i     (resolveValid_i),
    .resolveIndex_i     (resolveIndex_i),
    .resolveTarget_i    (resolveTarget_i),
    .resolveTaken_i     (resolveTaken_i),
    .resolveMispredict_i(resolveMispredict_i),
    .commit_i           (commit_i),
    .instValid_o        (instValid_o),
    .instPacket_o       (instPacket_o),
    .flagRecover_o      (flagRecover_o),
    .flagRtr_o          (flagRtr_o),
    .flagCall_o         (flagCall_o),
    .targetAddr_o       (targetAddr_o),
    .callPc_o           (callPc),
    .rasPush_o          (rasPush),
    .rasPop_o           (rasPop),
    .fs2Ready_o         (fs2Ready_o),
    .ctiQueueFull_o     (ctiQueueFull_o),
    .updatePc_o         (updatePc_o),
    .updateTarget_o     (updateTarget_o),
    .updateCtrlType_o   (updateCtrlType_o),
    .updateTaken_o      (updateTaken_o),
    .updateEn_o         (updateEn_o)
  );

  returnStack #(
    .RAS_DEPTH(RAS_DEPTH)
  ) u_returnStack (
    .clk       (clk),
    .reset_i   (reset_i),
    .push_i    (rasPush),
    .pop_i     (rasPop),
    .pushAddr_i(returnAddr),
    .rasTop_o  (rasTop)
  );

endmodule

`default_nettype wire

// ==== design/fetchStage2.sv ====
/*
 * Fetch stage 2: four slot predecode, first taken control
 * search, valid mask, recovery flags, control queue tags
 * and packet assembly
 */
`timescale 1ns/1ns
`default_nettype none

module fetchStage2 #(
  parameter int CTIQ_DEPTH = 16
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                fs1Ready_i,
  input  logic                stall_i,
  input  fetchPkg::pcT        pc_i,
  input  logic [fetchPkg::FETCH_WIDTH*fetchPkg::INST_WIDTH-1:0] instBundle_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0] btbHit_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0] prediction_i,
  input  fetchPkg::pcT        rasTop_i,
  input  logic                resolveValid_i,
  input  fetchPkg::ctiTagT    resolveIndex_i,
  input  fetchPkg::pcT        resolveTarget_i,
  input  logic                resolveTaken_i,
  input  logic                resolveMispredict_i,
  input  logic                commit_i,
  output logic [fetchPkg::FETCH_WIDTH-1:0] instValid_o,
  output logic [fetchPkg::FETCH_WIDTH*fetchPkg::PACKET_WIDTH-1:0] instPacket_o,
  output logic                flagRecover_o,
  output logic                flagRtr_o,
  output logic                flagCall_o,
  output fetchPkg::pcT        targetAddr_o,
  output fetchPkg::pcT        callPc_o,
  output logic                rasPush_o,
  output logic                rasPop_o,
  output logic                fs2Ready_o,
  output logic                ctiQueueFull_o,
  output fetchPkg::pcT        updatePc_o,
  output fetchPkg::pcT        updateTarget_o,
  output fetchPkg::ctrlTypeE  updateCtrlType_o,
  output logic                updateTaken_o,
  output logic                updateEn_o
);
  import fetchPkg::*;

  pcT        slotPc      [FETCH_WIDTH];
  instT      slotInst    [FETCH_WIDTH];
  ctrlTypeE  ctrlType    [FETCH_WIDTH];
  pcT        directTarget[FETCH_WIDTH];
  pcT        finalTarget [FETCH_WIDTH];
  ctiTagT    slotTag     [FETCH_WIDTH];
  logic [FETCH_WIDTH-1:0] isCtrl;
  logic [FETCH_WIDTH-1:0] takenCtrl;
  logic [FETCH_WIDTH-1:0] allocMask;
  logic [FETCH_WIDTH-1:0] allocTaken;
  logic [1:0] firstIdx;
  logic       hasTaken;
  logic       firstMiss;
  logic       fire;
  logic       queueFull;
  ctiTagT     allocTail;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per slot predecode and packets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar k = 0; k < FETCH_WIDTH; k++) begin : gSlot
    assign slotPc[k]   = pc_i + pcT'(4 * k);
    assign slotInst[k] = instBundle_i[k*INST_WIDTH +: INST_WIDTH];

    preDecode u_preDecode (
      .pc_i          (slotPc[k]),
      .inst_i        (slotInst[k]),
      .isCtrl_o      (isCtrl[k]),
      .ctrlType_o    (ctrlType[k]),
      .directTarget_o(directTarget[k])
    );

    assign takenCtrl[k]   = isCtrl[k] & (prediction_i[k] | (ctrlType[k] != CTRL_COND));
    assign finalTarget[k] = (isCtrl[k] && ctrlType[k] == CTRL_RETURN) ? rasTop_i
                                                                      : directTarget[k];
    assign instValid_o[k] = (2'(k) <= firstIdx);
    assign allocMask[k]   = isCtrl[k] & instValid_o[k];
    assign allocTaken[k]  = prediction_i[k] | (ctrlType[k] != CTRL_COND);
    assign instPacket_o[k*PACKET_WIDTH +: PACKET_WIDTH] =
      {slotInst[k], slotPc[k], finalTarget[k], slotTag[k], prediction_i[k]};
  end

  // lowest taken slot wins
  always_comb begin
    hasTaken = 1'b0;
    firstIdx = 2'd3;  // all slots valid when nothing taken
    for (int k = FETCH_WIDTH - 1; k >= 0; k--) begin
      if (takenCtrl[k]) begin
        hasTaken = 1'b1;
        firstIdx = 2'(k);
      end
    end
  end

  // tags follow the queue tail in slot order
  always_comb begin : tagGen
    ctiTagT runTag;
    runTag = allocTail;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      slotTag[k] = runTag & ctiTagT'(CTIQ_DEPTH - 1);
      runTag     = runTag + ctiTagT'(allocMask[k]);
    end
  end

  assign fire      = fs1Ready_i & ~stall_i & ~queueFull;
  assign firstMiss = hasTaken & ~btbHit_i[firstIdx];

  assign targetAddr_o   = finalTarget[firstIdx];
  assign callPc_o       = slotPc[firstIdx];
  assign flagRecover_o  = firstMiss & ~stall_i & ~queueFull;
  assign flagRtr_o      = firstMiss & (ctrlType[firstIdx] == CTRL_RETURN);
  assign flagCall_o     = firstMiss & (ctrlType[firstIdx] == CTRL_CALL);
  assign rasPush_o      = fire & hasTaken & (ctrlType[firstIdx] == CTRL_CALL);
  assign rasPop_o       = fire & hasTaken & (ctrlType[firstIdx] == CTRL_RETURN);
  assign fs2Ready_o     = fs1Ready_i & ~queueFull;
  assign ctiQueueFull_o = queueFull;

  ctrlQueue #(
    .CTIQ_DEPTH(CTIQ_DEPTH)
  ) u_ctrlQueue (
    .clk                (clk),
    .reset_i            (reset_i),
    .allocEn_i          (fire),
    .allocMask_i        (allocMask),
    .allocPc_i          (slotPc),
    .allocType_i        (ctrlType),
    .allocTarget_i      (finalTarget),
    .allocTaken_i       (allocTaken),
    .resolveValid_i     (resolveValid_i),
    .resolveIndex_i     (resolveIndex_i),
    .resolveTarget_i    (resolveTarget_i),
    .resolveTaken_i     (resolveTaken_i),
    .resolveMispredict_i(resolveMispredict_i),
    .commit_i           (commit_i),
    .allocTail_o        (allocTail),
    .ctiQueueFull_o     (queueFull),
    .updatePc_o         (updatePc_o),
    .updateTarget_o     (updateTarget_o),
    .updateCtrlType_o   (updateCtrlType_o),
    .updateTaken_o      (updateTaken_o),
    .updateEn_o         (updateEn_o)
  );

endmodule

`default_nettype wire

// ==== design/ctrlQueue.sv ====
/*
 * Circular control instruction queue: in order allocate,
 * execute resolve with squash, head commit and predictor
 * update outputs
 */
`timescale 1ns/1ns
`default_nettype none

module ctrlQueue #(
  parameter int CTIQ_DEPTH = 16
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               allocEn_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0] allocMask_i,
  input  fetchPkg::pcT       allocPc_i    [fetchPkg::FETCH_WIDTH],
  input  fetchPkg::ctrlTypeE allocType_i  [fetchPkg::FETCH_WIDTH],
  input  fetchPkg::pcT       allocTarget_i[fetchPkg::FETCH_WIDTH],
  input  logic [fetchPkg::FETCH_WIDTH-1:0] allocTaken_i,
  input  logic               resolveValid_i,
  input  fetchPkg::ctiTagT   resolveIndex_i,
  input  fetchPkg::pcT       resolveTarget_i,
  input  logic               resolveTaken_i,
  input  logic               resolveMispredict_i,
  input  logic               commit_i,
  output fetchPkg::ctiTagT   allocTail_o,
  output logic               ctiQueueFull_o,
  output fetchPkg::pcT       updatePc_o,
  output fetchPkg::pcT       updateTarget_o,
  output fetchPkg::ctrlTypeE updateCtrlType_o,
  output logic               updateTaken_o,
  output logic               updateEn_o
);
  import fetchPkg::*;

  localparam int PTR_W = $clog2(CTIQ_DEPTH);

  pcT        qPc    [CTIQ_DEPTH];
  ctrlTypeE  qType  [CTIQ_DEPTH];
  pcT        qTarget[CTIQ_DEPTH];
  logic [CTIQ_DEPTH-1:0] qTaken;

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;
  logic [PTR_W:0]   cntBase;
  logic [PTR_W-1:0] allocIdx[FETCH_WIDTH];
  logic [PTR_W-1:0] resIdx;
  logic [2:0]       allocNum;
  logic             squash;
  logic             doAlloc;
  logic             retire;

  assign resIdx  = resolveIndex_i[PTR_W-1:0];
  assign squash  = resolveValid_i & resolveMispredict_i;
  assign doAlloc = allocEn_i & ~squash;  // squash cycle drops the bundle
  assign retire  = commit_i & (count != '0);

  assign allocTail_o    = ctiTagT'(tail);
  assign ctiQueueFull_o = (count > (PTR_W+1)'(CTIQ_DEPTH - FETCH_WIDTH));

  // packed write slots in mask order
  always_comb begin
    allocNum = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      allocIdx[k] = tail + PTR_W'(allocNum);
      allocNum    = allocNum + 3'(allocMask_i[k]);
    end
  end

  always_comb begin
    if (squash) begin
      cntBase = {1'b0, PTR_W'(resIdx - head)} + 1'b1;  // keep head..resIdx
    end else if (doAlloc) begin
      cntBase = count + (PTR_W+1)'(allocNum);
    end else begin
      cntBase = count;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and count
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset_i) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      updateEn_o <= 1'b0;
    end else begin
      count      <= cntBase - (PTR_W+1)'(retire);
      updateEn_o <= retire;
      if (retire) head <= head + 1'b1;
      if (squash) begin
        tail <= resIdx + 1'b1;
      end else if (doAlloc) begin
        tail <= tail + PTR_W'(allocNum);
      end
    end
  end

  // entry storage and update payload
  always_ff @(posedge clk) begin
    if (doAlloc) begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        if (allocMask_i[k]) begin
          qPc[allocIdx[k]]     <= allocPc_i[k];
          qType[allocIdx[k]]   <= allocType_i[k];
          qTarget[allocIdx[k]] <= allocTarget_i[k];
          qTaken[allocIdx[k]]  <= allocTaken_i[k];
        end
      end
    end
    if (resolveValid_i) begin
      qTarget[resIdx] <= resolveTarget_i;  // execute outcome wins
      qTaken[resIdx]  <= resolveTaken_i;
    end
    if (retire) begin
      updatePc_o       <= qPc[head];
      updateTarget_o   <= qTarget[head];
      updateCtrlType_o <= qType[head];
      updateTaken_o    <= qTaken[head];
    end
  end

endmodule

`default_nettype wire

// ==== design/returnStack.sv ====
/*
 * Circular return address stack, push above the pointer,
 * pop by moving the pointer back
 */
`timescale 1ns/1ns
`default_nettype none

module returnStack #(
  parameter int RAS_DEPTH = 8
) (
  input  logic         clk,
  input  logic         reset_i,
  input  logic         push_i,
  input  logic         pop_i,
  input  fetchPkg::pcT pushAddr_i,
  output fetchPkg::pcT rasTop_o
);
  import fetchPkg::*;

  localparam int PTR_W = $clog2(RAS_DEPTH);

  pcT               stack[RAS_DEPTH];
  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] ptrUp;

  assign ptrUp    = ptr + 1'b1;  // wraps onto the oldest entry
  assign rasTop_o = stack[ptr];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ptr <= '0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        stack[i] <= '0;
      end
    end else if (push_i) begin
      stack[ptrUp] <= pushAddr_i;
      ptr          <= ptrUp;
    end else if (pop_i) begin
      ptr <= ptr - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/preDecode.sv ====
/*
 * Single slot predecoder: control class, control type
 * and the PC relative direct target
 */
`timescale 1ns/1ns
`default_nettype none

module preDecode (
  input  fetchPkg::pcT       pc_i,
  input  fetchPkg::instT     inst_i,
  output logic               isCtrl_o,
  output fetchPkg::ctrlTypeE ctrlType_o,
  output fetchPkg::pcT       directTarget_o
);
  import fetchPkg::*;

  opClassT opClass;
  pcT      offset;

  assign opClass = inst_i[31:29];
  // word offset, sign extended
  assign offset = {{(PC_WIDTH-18){inst_i[15]}}, inst_i[15:0], 2'b00};
  assign directTarget_o = pc_i + offset;

  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = CTRL_JUMP;
    case (opClass)
      OPC_COND:   ctrlType_o = CTRL_COND;
      OPC_JUMP:   ctrlType_o = CTRL_JUMP;
      OPC_CALL:   ctrlType_o = CTRL_CALL;
      OPC_RETURN: ctrlType_o = CTRL_RETURN;
      default:    isCtrl_o = 1'b0;  // plain instruction
    endcase
  end

endmodule

`default_nettype wire

// ==== design/fetchPkg.sv ====
/*
 * Fetch slice shared definitions: widths, vector types,
 * opcode classes, control transfer type and packet width
 */
`default_nettype none

package fetchPkg;

  localparam int FETCH_WIDTH = 4;  // slots per bundle
  localparam int PC_WIDTH    = 32;
  localparam int INST_WIDTH  = 32;
  localparam int TAG_WIDTH   = 4;  // covers queue depths up to 16

  typedef logic [PC_WIDTH-1:0]   pcT;
  typedef logic [INST_WIDTH-1:0] instT;
  typedef logic [TAG_WIDTH-1:0]  ctiTagT;
  typedef logic [2:0]            opClassT;  // inst bits 31:29

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcode classes, anything else is not a control instruction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam opClassT OPC_COND   = 3'b100;
  localparam opClassT OPC_JUMP   = 3'b101;
  localparam opClassT OPC_CALL   = 3'b110;
  localparam opClassT OPC_RETURN = 3'b111;

  typedef enum logic [1:0] {
    CTRL_RETURN = 2'd0,
    CTRL_CALL   = 2'd1,
    CTRL_JUMP   = 2'd2,
    CTRL_COND   = 2'd3
  } ctrlTypeE;

  // {inst, pc, final target, tag, prediction}
  localparam int PACKET_WIDTH = INST_WIDTH + 2 * PC_WIDTH + TAG_WIDTH + 1;

endpackage

`default_nettype wire
